// ==== dcache_pkg.sv ====
// shared geometry, bus structs and state encodings of the L1 data cache
package dcache_pkg;

  //////////////////////////////////////////////////
  // geometry
  //////////////////////////////////////////////////

  localparam int unsigned PADDR_W       = 32;
  localparam int unsigned WORD_W        = 32;
  localparam int unsigned NUM_WAYS      = 2;
  localparam int unsigned LINE_WORDS    = 4;
  localparam int unsigned LINE_W        = LINE_WORDS * WORD_W;
  localparam int unsigned IDX_W         = 4;
  localparam int unsigned OFF_W         = 4;
  localparam int unsigned TAG_W         = PADDR_W - IDX_W - OFF_W;
  localparam int unsigned NUM_SETS      = 1 << IDX_W;
  // word select inside a line, byte select inside a word
  localparam int unsigned WSEL_W        = $clog2(LINE_WORDS);
  localparam int unsigned BYTE_W        = OFF_W - WSEL_W;
  localparam int unsigned WAY_W         = $clog2(NUM_WAYS);
  localparam int unsigned ID_W          = 4;
  // memory side flow control
  localparam int unsigned MEM_CREDITS   = 2;
  localparam int unsigned CRED_W        = $clog2(MEM_CREDITS + 1);
  // upper half of the address space is I/O
  localparam int unsigned NC_REGION_BIT = 31;

  //////////////////////////////////////////////////
  // core and memory ports
  //////////////////////////////////////////////////

  typedef struct packed {
    logic                   req;
    logic [IDX_W+OFF_W-1:0] index;
    logic [TAG_W-1:0]       tag;
    logic                   tag_valid;
    logic                   kill;
    logic [ID_W-1:0]        id;
  } core_req_t;

  typedef struct packed {
    logic              gnt;
    logic              rvalid;
    logic [WORD_W-1:0] rdata;
    logic [ID_W-1:0]   rid;
  } core_rsp_t;

  typedef enum logic {
    SZ_WORD,
    SZ_LINE
  } mem_size_e;

  typedef struct packed {
    logic               valid;
    logic [PADDR_W-1:0] paddr;
    mem_size_e          size;
  } mem_req_t;

  // word returns sit in lane zero
  typedef struct packed {
    logic              valid;
    logic [LINE_W-1:0] data;
  } mem_rtrn_t;

  //////////////////////////////////////////////////
  // FSM encodings
  //////////////////////////////////////////////////

  typedef enum logic [2:0] {
    IDLE,
    READ,
    MISS_REQ,
    MISS_WAIT,
    KILL_MISS,
    KILL_MISS_ACK,
    REPLAY_REQ,
    REPLAY_READ
  } rd_state_e;

  typedef enum logic {
    MU_IDLE,
    MU_WAIT_RTRN
  } miss_state_e;

endpackage

// ==== dcache_rd_ctrl.sv ====
// load port controller of the L1 data cache with hit check, miss, replay and kill handling
`timescale 1ns/1ns

module dcache_rd_ctrl import dcache_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                cache_en_i,
  // core load port
  input  core_req_t           core_req_i,
  output core_rsp_t           core_rsp_o,
  // tag and data arrays
  output logic                rd_req_o,
  output logic [IDX_W-1:0]    rd_idx_o,
  output logic [OFF_W-1:0]    rd_off_o,
  // tag comes one cycle after the read
  output logic [TAG_W-1:0]    rd_tag_o,
  input  logic                rd_ack_i,
  input  logic [WORD_W-1:0]   rd_data_i,
  input  logic [NUM_WAYS-1:0] rd_vld_bits_i,
  input  logic [NUM_WAYS-1:0] rd_hit_oh_i,
  // refill write in progress
  input  logic                wr_cl_vld_i,
  // miss unit
  output logic                miss_req_o,
  input  logic                miss_ack_i,
  input  logic                miss_replay_i,
  input  logic                miss_rtrn_vld_i,
  input  logic [WORD_W-1:0]   miss_rdata_i,
  output logic [PADDR_W-1:0]  miss_paddr_o,
  output logic                miss_nc_o,
  output logic [NUM_WAYS-1:0] miss_vld_bits_o
);

  rd_state_e state_d, state_q;

  logic [TAG_W-1:0]    tag_d, tag_q;
  logic [IDX_W-1:0]    idx_d, idx_q;
  logic [OFF_W-1:0]    off_d, off_q;
  logic [ID_W-1:0]     id_d, id_q;
  logic [NUM_WAYS-1:0] vld_d, vld_q;
  logic                save_tag;
  logic                gnt, rvalid;
  logic                rd_req_q, rd_ack_q;
  logic [WORD_W-1:0]   rdata;

  //////////////////////////////////////////////////
  // address capture
  //////////////////////////////////////////////////

  // index and offset on grant, tag once it is valid
  assign idx_d = gnt ? core_req_i.index[IDX_W+OFF_W-1:OFF_W] : idx_q;
  assign off_d = gnt ? core_req_i.index[OFF_W-1:0] : off_q;
  assign id_d  = gnt ? core_req_i.id : id_q;
  assign tag_d = save_tag ? core_req_i.tag : tag_q;
  // valid bits of the set as seen by the last read
  assign vld_d = rd_req_q ? rd_vld_bits_i : vld_q;

  // arrays see the next address so a back to back read starts at once
  assign rd_idx_o = idx_d;
  assign rd_off_o = off_d;
  assign rd_tag_o = tag_d;

  // miss returns bypass the arrays
  assign rdata = (state_q == MISS_WAIT) ? miss_rdata_i : rd_data_i;

  assign core_rsp_o = '{gnt: gnt, rvalid: rvalid, rdata: rdata, rid: id_q};

  assign miss_paddr_o    = {tag_q, idx_q, off_q};
  assign miss_vld_bits_o = vld_q;
  // I/O region or cache off
  assign miss_nc_o = ~cache_en_i | tag_q[NC_REGION_BIT-IDX_W-OFF_W];

  //////////////////////////////////////////////////
  // control FSM
  //////////////////////////////////////////////////

  always_comb begin : p_fsm
    state_d    = state_q;
    save_tag   = 1'b0;
    rd_req_o   = 1'b0;
    miss_req_o = 1'b0;
    gnt        = 1'b0;
    rvalid     = 1'b0;

    unique case (state_q)
      // wait for a load, grant only when the array takes the read
      IDLE: begin
        if (core_req_i.req) begin
          rd_req_o = 1'b1;
          if (rd_ack_i) begin
            gnt     = 1'b1;
            state_d = READ;
          end
        end
      end
      // tag compare, keep reading the set until the tag shows up
      READ, REPLAY_READ: begin
        rd_req_o = 1'b1;
        if (core_req_i.kill) begin
          rvalid  = 1'b1;
          state_d = IDLE;
        end else if (core_req_i.tag_valid || state_q == REPLAY_READ) begin
          save_tag = (state_q != REPLAY_READ);
          if (wr_cl_vld_i || !rd_ack_q) begin
            // read collided with a refill
            state_d = REPLAY_REQ;
          end else if ((|rd_hit_oh_i) && cache_en_i) begin
            rvalid  = 1'b1;
            state_d = IDLE;
            // overlap with the next load
            if (core_req_i.req && rd_ack_i) begin
              gnt     = 1'b1;
              state_d = READ;
            end
          end else begin
            state_d = MISS_REQ;
          end
        end
      end
      // hand the miss over
      MISS_REQ: begin
        miss_req_o = 1'b1;
        if (core_req_i.kill) begin
          rvalid  = 1'b1;
          state_d = miss_ack_i ? KILL_MISS : KILL_MISS_ACK;
        end else if (miss_replay_i) begin
          state_d = REPLAY_REQ;
        end else if (miss_ack_i) begin
          state_d = MISS_WAIT;
        end
      end
      // memory transaction in flight
      MISS_WAIT: begin
        if (core_req_i.kill) begin
          rvalid  = 1'b1;
          state_d = miss_rtrn_vld_i ? IDLE : KILL_MISS;
        end else if (miss_rtrn_vld_i) begin
          rvalid  = 1'b1;
          state_d = IDLE;
        end
      end
      // read the set again
      REPLAY_REQ: begin
        rd_req_o = 1'b1;
        if (core_req_i.kill) begin
          rvalid  = 1'b1;
          state_d = IDLE;
        end else if (rd_ack_i) begin
          state_d = REPLAY_READ;
        end
      end
      // killed before the miss unit answered
      KILL_MISS_ACK: begin
        miss_req_o = 1'b1;
        if (miss_replay_i) begin
          state_d = IDLE;
        end else if (miss_ack_i) begin
          state_d = KILL_MISS;
        end
      end
      // drain the return of a killed miss
      KILL_MISS: begin
        if (miss_rtrn_vld_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl_regs
    if (!rst_ni) begin
      state_q  <= IDLE;
      rd_req_q <= 1'b0;
      rd_ack_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      rd_req_q <= rd_req_o;
      rd_ack_q <= rd_ack_i;
    end
  end

  always_ff @(posedge clk_i) begin : p_addr_regs
    tag_q <= tag_d;
    idx_q <= idx_d;
    off_q <= off_d;
    id_q  <= id_d;
    vld_q <= vld_d;
  end

endmodule

// ==== dcache_mem.sv ====
// two-way tag, valid and data arrays of the L1 data cache with tag compare and refill port
`timescale 1ns/1ns

module dcache_mem import dcache_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  // read port
  input  logic                rd_req_i,
  input  logic [IDX_W-1:0]    rd_idx_i,
  input  logic [OFF_W-1:0]    rd_off_i,
  input  logic [TAG_W-1:0]    rd_tag_i,
  output logic                rd_ack_o,
  output logic [WORD_W-1:0]   rd_data_o,
  output logic [NUM_WAYS-1:0] rd_vld_bits_o,
  output logic [NUM_WAYS-1:0] rd_hit_oh_o,
  // refill port
  input  logic                wr_req_i,
  input  logic [IDX_W-1:0]    wr_idx_i,
  input  logic [NUM_WAYS-1:0] wr_way_i,
  input  logic [TAG_W-1:0]    wr_tag_i,
  input  logic [LINE_W-1:0]   wr_line_i,
  output logic                wr_cl_vld_o
);

  logic [NUM_WAYS-1:0] vld_q [NUM_SETS];
  logic [TAG_W-1:0]    tag_mem [NUM_WAYS][NUM_SETS];
  logic [LINE_W-1:0]   line_mem [NUM_WAYS][NUM_SETS];

  // read stage
  logic [TAG_W-1:0]    rd_tag_q [NUM_WAYS];
  logic [WORD_W-1:0]   rd_word_q [NUM_WAYS];
  logic [NUM_WAYS-1:0] rd_vld_q;
  logic [NUM_WAYS-1:0] hit;
  logic [WSEL_W-1:0]   rd_wsel;
  logic                rd_en;

  // refill wins the array
  assign rd_en       = rd_req_i & ~wr_req_i;
  assign rd_ack_o    = ~wr_req_i;
  assign wr_cl_vld_o = wr_req_i;
  assign rd_wsel     = rd_off_i[OFF_W-1:BYTE_W];

  //////////////////////////////////////////////////
  // valid bits
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_vld
    if (!rst_ni) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        vld_q[s] <= '0;
      end
      rd_vld_q <= '0;
    end else begin
      if (wr_req_i) begin
        vld_q[wr_idx_i] <= vld_q[wr_idx_i] | wr_way_i;
      end
      if (rd_en) begin
        rd_vld_q <= vld_q[rd_idx_i];
      end
    end
  end

  //////////////////////////////////////////////////
  // tags and lines
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin : p_arrays
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (wr_req_i && wr_way_i[w]) begin
        tag_mem[w][wr_idx_i]  <= wr_tag_i;
        line_mem[w][wr_idx_i] <= wr_line_i;
      end
      // word of every way, tag compare next cycle
      if (rd_en) begin
        rd_tag_q[w]  <= tag_mem[w][rd_idx_i];
        rd_word_q[w] <= line_mem[w][rd_idx_i][rd_wsel*WORD_W +: WORD_W];
      end
    end
  end

  // compare against the tag presented now
  always_comb begin : p_hit
    rd_data_o = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit[w] = rd_vld_q[w] & (rd_tag_q[w] == rd_tag_i);
      if (hit[w]) begin
        rd_data_o = rd_data_o | rd_word_q[w];
      end
    end
  end

  assign rd_hit_oh_o   = hit;
  assign rd_vld_bits_o = rd_vld_q;

endmodule

// ==== dcache_miss_unit.sv ====
// miss unit of the L1 data cache with victim choice, memory credits and refill
`timescale 1ns/1ns

module dcache_miss_unit import dcache_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  // controller
  input  logic                miss_req_i,
  input  logic [PADDR_W-1:0]  miss_paddr_i,
  input  logic                miss_nc_i,
  input  logic [NUM_WAYS-1:0] miss_vld_bits_i,
  output logic                miss_ack_o,
  output logic                miss_replay_o,
  output logic                miss_rtrn_vld_o,
  output logic [WORD_W-1:0]   miss_rdata_o,
  // memory
  output mem_req_t            mem_req_o,
  input  mem_rtrn_t           mem_rtrn_i,
  input  logic                mem_credit_i,
  // refill write
  output logic                wr_req_o,
  output logic [IDX_W-1:0]    wr_idx_o,
  output logic [NUM_WAYS-1:0] wr_way_o,
  output logic [TAG_W-1:0]    wr_tag_o,
  output logic [LINE_W-1:0]   wr_line_o
);

  miss_state_e state_d, state_q;

  logic [CRED_W-1:0]   credit_q;
  logic [WAY_W-1:0]    rr_q;
  logic [NUM_WAYS-1:0] victim;
  logic                spend;
  // outstanding miss
  logic [PADDR_W-1:0]  paddr_q;
  mem_size_e           size_q;
  logic [NUM_WAYS-1:0] way_q;
  logic [WSEL_W-1:0]   wsel;

  // lowest invalid way, else round robin
  always_comb begin : p_victim
    victim       = '0;
    victim[rr_q] = 1'b1;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!miss_vld_bits_i[w]) begin
        victim    = '0;
        victim[w] = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // miss FSM
  //////////////////////////////////////////////////

  always_comb begin : p_fsm
    state_d         = state_q;
    spend           = 1'b0;
    miss_ack_o      = 1'b0;
    miss_replay_o   = 1'b0;
    miss_rtrn_vld_o = 1'b0;

    unique case (state_q)
      MU_IDLE: begin
        if (miss_req_i) begin
          // no credit, no request
          if (credit_q != '0) begin
            spend      = 1'b1;
            miss_ack_o = 1'b1;
            state_d    = MU_WAIT_RTRN;
          end else begin
            miss_replay_o = 1'b1;
          end
        end
      end
      MU_WAIT_RTRN: begin
        // one miss at a time
        miss_replay_o = miss_req_i;
        if (mem_rtrn_i.valid) begin
          miss_rtrn_vld_o = 1'b1;
          state_d         = MU_IDLE;
        end
      end
      default: begin
        state_d = MU_IDLE;
      end
    endcase
  end

  assign mem_req_o = '{
    valid: spend,
    paddr: miss_nc_i ? {miss_paddr_i[PADDR_W-1:BYTE_W], {BYTE_W{1'b0}}}
                     : {miss_paddr_i[PADDR_W-1:OFF_W], {OFF_W{1'b0}}},
    size:  miss_nc_i ? SZ_WORD : SZ_LINE
  };

  // requested word out of the line, lane zero for a word return
  assign wsel         = paddr_q[OFF_W-1:BYTE_W];
  assign miss_rdata_o = (size_q == SZ_WORD) ? mem_rtrn_i.data[WORD_W-1:0]
                                            : mem_rtrn_i.data[wsel*WORD_W +: WORD_W];

  // refill only for line requests
  assign wr_req_o  = miss_rtrn_vld_o & (size_q == SZ_LINE);
  assign wr_idx_o  = paddr_q[OFF_W +: IDX_W];
  assign wr_tag_o  = paddr_q[PADDR_W-1 -: TAG_W];
  assign wr_way_o  = way_q;
  assign wr_line_o = mem_rtrn_i.data;

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl_regs
    if (!rst_ni) begin
      state_q  <= MU_IDLE;
      credit_q <= CRED_W'(MEM_CREDITS);
      rr_q     <= '0;
    end else begin
      state_q  <= state_d;
      credit_q <= credit_q - CRED_W'(spend) + CRED_W'(mem_credit_i);
      if (wr_req_o) begin
        rr_q <= rr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin : p_miss_regs
    if (spend) begin
      paddr_q <= miss_paddr_i;
      size_q  <= miss_nc_i ? SZ_WORD : SZ_LINE;
      way_q   <= victim;
    end
  end

endmodule

// ==== dcache_top.sv ====
// L1 data cache subsystem joining load controller, arrays and miss unit
`timescale 1ns/1ns

module dcache_top import dcache_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      cache_en_i,
  input  core_req_t core_req_i,
  output core_rsp_t core_rsp_o,
  output mem_req_t  mem_req_o,
  input  mem_rtrn_t mem_rtrn_i,
  input  logic      mem_credit_i
);

  // controller to arrays
  logic                rd_req, rd_ack;
  logic [IDX_W-1:0]    rd_idx;
  logic [OFF_W-1:0]    rd_off;
  logic [TAG_W-1:0]    rd_tag;
  logic [WORD_W-1:0]   rd_data;
  logic [NUM_WAYS-1:0] rd_vld_bits, rd_hit_oh;
  logic                wr_cl_vld;

  // controller to miss unit
  logic                miss_req, miss_ack, miss_replay, miss_rtrn_vld, miss_nc;
  logic [WORD_W-1:0]   miss_rdata;
  logic [PADDR_W-1:0]  miss_paddr;
  logic [NUM_WAYS-1:0] miss_vld_bits;

  // refill
  logic                wr_req;
  logic [IDX_W-1:0]    wr_idx;
  logic [NUM_WAYS-1:0] wr_way;
  logic [TAG_W-1:0]    wr_tag;
  logic [LINE_W-1:0]   wr_line;

  dcache_rd_ctrl dcache_rd_ctrl_i (
    .clk_i, .rst_ni, .cache_en_i, .core_req_i, .core_rsp_o,
    .rd_req_o(rd_req), .rd_idx_o(rd_idx), .rd_off_o(rd_off), .rd_tag_o(rd_tag),
    .rd_ack_i(rd_ack), .rd_data_i(rd_data), .rd_vld_bits_i(rd_vld_bits),
    .rd_hit_oh_i(rd_hit_oh), .wr_cl_vld_i(wr_cl_vld),
    .miss_req_o(miss_req), .miss_ack_i(miss_ack), .miss_replay_i(miss_replay),
    .miss_rtrn_vld_i(miss_rtrn_vld), .miss_rdata_i(miss_rdata),
    .miss_paddr_o(miss_paddr), .miss_nc_o(miss_nc), .miss_vld_bits_o(miss_vld_bits)
  );

  dcache_mem dcache_mem_i (
    .clk_i, .rst_ni,
    .rd_req_i(rd_req), .rd_idx_i(rd_idx), .rd_off_i(rd_off), .rd_tag_i(rd_tag),
    .rd_ack_o(rd_ack), .rd_data_o(rd_data), .rd_vld_bits_o(rd_vld_bits),
    .rd_hit_oh_o(rd_hit_oh),
    .wr_req_i(wr_req), .wr_idx_i(wr_idx), .wr_way_i(wr_way), .wr_tag_i(wr_tag),
    .wr_line_i(wr_line), .wr_cl_vld_o(wr_cl_vld)
  );

  dcache_miss_unit dcache_miss_unit_i (
    .clk_i, .rst_ni,
    .miss_req_i(miss_req), .miss_paddr_i(miss_paddr), .miss_nc_i(miss_nc),
    .miss_vld_bits_i(miss_vld_bits), .miss_ack_o(miss_ack), .miss_replay_o(miss_replay),
    .miss_rtrn_vld_o(miss_rtrn_vld), .miss_rdata_o(miss_rdata),
    .mem_req_o, .mem_rtrn_i, .mem_credit_i,
    .wr_req_o(wr_req), .wr_idx_o(wr_idx), .wr_way_o(wr_way), .wr_tag_o(wr_tag),
    .wr_line_o(wr_line)
  );

endmodule

// ==== tb_dcache_assert.sv ====
// concurrent checks on the L1 data cache load handshake, hit vector and memory credits
`timescale 1ns/1ns

module tb_dcache_assert import dcache_pkg::*; (
  input logic                clk_i,
  input logic                rst_ni,
  input core_req_t           core_req_i,
  input core_rsp_t           core_rsp_i,
  input mem_req_t            mem_req_i,
  input logic                mem_credit_i,
  input logic [NUM_WAYS-1:0] rd_hit_oh_i
);

  // credits the miss unit may still spend
  int unsigned avail_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_credits
    if (!rst_ni) begin
      avail_q <= MEM_CREDITS;
    end else begin
      avail_q <= avail_q - (mem_req_i.valid ? 1 : 0) + (mem_credit_i ? 1 : 0);
    end
  end

  // at most one way hits
  a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(rd_hit_oh_i))
    else $error("hit vector has more than one way set");

  a_gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_rsp_i.gnt |-> core_req_i.req)
    else $error("grant without a load request");

  // no request without a credit
  a_mem_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_i.valid |-> (avail_q != 0))
    else $error("memory request with no credit left");

endmodule

bind dcache_top tb_dcache_assert tb_dcache_assert_i (
  .clk_i,
  .rst_ni,
  .core_req_i,
  .core_rsp_i(core_rsp_o),
  .mem_req_i(mem_req_o),
  .mem_credit_i,
  .rd_hit_oh_i(rd_hit_oh)
);

// ==== tb_dcache.sv ====
// testbench of the L1 data cache with credit based memory model, load driver and data check
`timescale 1ns/1ns

module tb_dcache import dcache_pkg::*; ();

  localparam int unsigned CLK_HALF    = 20;
  localparam int unsigned NUM_RANDOM  = 200;
  // directed loads of tests 1 to 5 plus the random run
  localparam int unsigned TOTAL_LOADS = 12 + 5 + 6 + 4 + 4 + NUM_RANDOM;
  localparam int unsigned MAX_CYCLES  = 40 * TOTAL_LOADS;
  localparam logic [31:0] MEM_KEY     = 32'h5a3c_96e1;

  logic      clk;
  logic      rst_n;
  logic      cache_en;
  core_req_t core_req;
  core_rsp_t core_rsp;
  mem_req_t  mem_req;
  mem_rtrn_t mem_rtrn;
  logic      mem_credit;

  int unsigned     cycle;
  int unsigned     errors, checks, loads;
  // n_rtrn counts returns taken by the miss unit
  int unsigned     n_line_req, n_word_req, n_rtrn, n_replay;
  int              tb_credits;
  int              credits_owed;
  bit              hold_credits;
  logic [ID_W-1:0] next_id;

  // memory requests waiting for their return
  logic [PADDR_W-1:0] rq_addr[$];
  mem_size_e          rq_size[$];
  int unsigned        rq_due[$];
  // granted loads waiting for rvalid
  logic [PADDR_W-1:0] exp_addr[$];
  logic [ID_W-1:0]    exp_id[$];

  dcache_top dcache_top_i (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .cache_en_i  (cache_en),
    .core_req_i  (core_req),
    .core_rsp_o  (core_rsp),
    .mem_req_o   (mem_req),
    .mem_rtrn_i  (mem_rtrn),
    .mem_credit_i(mem_credit)
  );

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  // memory content is the word address scrambled with a key
  function automatic logic [WORD_W-1:0] mem_word(input logic [PADDR_W-1:0] addr);
    return {2'b00, addr[PADDR_W-1:2]} ^ MEM_KEY;
  endfunction

  function automatic logic [LINE_W-1:0] line_data(input logic [PADDR_W-1:0] addr,
                                                  input mem_size_e size);
    logic [LINE_W-1:0] line;
    line = '0;
    if (size == SZ_WORD) begin
      line[WORD_W-1:0] = mem_word(addr);
    end else begin
      for (int w = 0; w < LINE_WORDS; w++) begin
        line[w*WORD_W +: WORD_W] = mem_word({addr[PADDR_W-1:OFF_W], 2'(w), 2'b00});
      end
    end
    return line;
  endfunction

  function automatic logic [PADDR_W-1:0] make_addr(input logic [TAG_W-1:0] tag,
                                                   input logic [IDX_W-1:0] idx,
                                                   input int unsigned word);
    return {tag, idx, 2'(word), 2'b00};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s got 0x%08h expected 0x%08h at cycle %0d", name, got, exp, cycle);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("error at cycle %0d: %s", cycle, msg);
  endtask

  //////////////////////////////////////////////////
  // clock and cycle limit
  //////////////////////////////////////////////////

  initial begin : p_clk
    clk = 1'b0;
    forever begin
      #CLK_HALF clk = ~clk;
    end
  end

  initial begin : p_timeout
    cycle = 0;
    while (cycle < MAX_CYCLES) begin
      @(posedge clk);
      cycle++;
    end
    $display("timeout: run did not end within %0d cycles", MAX_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // memory model
  //////////////////////////////////////////////////

  // sample requests and credit use mid cycle
  initial begin : p_mem_sample
    forever begin
      @(negedge clk);
      if (rst_n) begin
        if (mem_req.valid) begin
          if (tb_credits <= 0) begin
            report_error("memory request issued with no credit left");
          end
          tb_credits--;
          rq_addr.push_back(mem_req.paddr);
          rq_size.push_back(mem_req.size);
          rq_due.push_back(cycle + $urandom_range(2, 6));
          if (mem_req.size == SZ_LINE) begin
            n_line_req++;
          end else begin
            n_word_req++;
          end
        end
        if (mem_credit) begin
          tb_credits++;
        end
        if (dcache_top_i.miss_replay) begin
          n_replay++;
        end
        if (dcache_top_i.miss_rtrn_vld) begin
          n_rtrn++;
        end
      end
    end
  end

  // data and credit go back together unless credits are held
  initial begin : p_mem_drive
    forever begin
      @(posedge clk);
      #2;
      mem_rtrn   = '0;
      mem_credit = 1'b0;
      if (rq_due.size() > 0 && rq_due[0] <= cycle) begin
        mem_rtrn.valid = 1'b1;
        mem_rtrn.data  = line_data(rq_addr[0], rq_size[0]);
        void'(rq_addr.pop_front());
        void'(rq_size.pop_front());
        void'(rq_due.pop_front());
        credits_owed++;
      end
      if (credits_owed > 0 && !hold_credits) begin
        mem_credit = 1'b1;
        credits_owed--;
      end
    end
  end

  //////////////////////////////////////////////////
  // response compare
  //////////////////////////////////////////////////

  initial begin : p_compare
    logic [PADDR_W-1:0] addr;
    logic [ID_W-1:0]    id;
    forever begin
      @(negedge clk);
      // tag belongs to the newest load granted before this cycle
      if (rst_n && core_req.tag_valid && exp_addr.size() > 0) begin
        addr = exp_addr[exp_addr.size() - 1];
        addr[PADDR_W-1 -: TAG_W] = core_req.tag;
        exp_addr[exp_addr.size() - 1] = addr;
      end
      // tag filled in once it is valid
      if (rst_n && core_rsp.gnt) begin
        exp_addr.push_back({{TAG_W{1'b0}}, core_req.index});
        exp_id.push_back(core_req.id);
      end
      if (rst_n && core_rsp.rvalid) begin
        if (exp_addr.size() == 0) begin
          report_error("rvalid with no load outstanding");
        end else begin
          addr = exp_addr.pop_front();
          id   = exp_id.pop_front();
          check_value("rid", core_rsp.rid, id);
          // data of a killed load is undefined
          if (!core_req.kill) begin
            check_value("rdata", core_rsp.rdata, mem_word(addr));
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // load driver
  //////////////////////////////////////////////////

  // kill_at below zero means no kill
  // cycles count from the one after gnt
  // tag bus carries the inverted tag outside the tag_valid cycle
  task automatic run_load(input logic [PADDR_W-1:0] addr, input int tag_delay,
                          input int kill_at);
    int cyc;
    bit granted;
    bit done;
    @(posedge clk);
    #2;
    core_req.req       = 1'b1;
    core_req.index     = addr[IDX_W+OFF_W-1:0];
    core_req.tag       = ~addr[PADDR_W-1 -: TAG_W];
    core_req.id        = next_id;
    core_req.tag_valid = 1'b0;
    core_req.kill      = 1'b0;
    granted = 1'b0;
    while (!granted) begin
      @(negedge clk);
      granted = core_rsp.gnt;
      @(posedge clk);
      #2;
    end
    core_req.req = 1'b0;
    next_id++;
    loads++;
    cyc  = 0;
    done = 1'b0;
    while (!done) begin
      core_req.tag_valid = (cyc == tag_delay);
      core_req.tag       = (cyc == tag_delay) ? addr[PADDR_W-1 -: TAG_W]
                                              : ~addr[PADDR_W-1 -: TAG_W];
      core_req.kill      = (cyc == kill_at);
      @(negedge clk);
      done = core_rsp.rvalid;
      @(posedge clk);
      #2;
      cyc++;
    end
    core_req.tag_valid = 1'b0;
    core_req.kill      = 1'b0;
  endtask

  // wait until all returns and credits are back
  task automatic wait_quiet();
    while (rq_due.size() != 0 || credits_owed != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    #2;
  endtask

  task automatic finish_test(input int num, input string name, input int unsigned err_start);
    if (errors == err_start) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d errors", num, name, errors - err_start);
    end
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  initial begin : p_main
    int unsigned        err_start, line_start, word_start, replay_start, d;
    logic [PADDR_W-1:0] addr;
    logic [TAG_W-1:0]   tag;
    int                 tag_delay, kill_at;
    void'($urandom(25));
    rst_n        = 1'b0;
    cache_en     = 1'b1;
    core_req     = '0;
    mem_rtrn     = '0;
    mem_credit   = 1'b0;
    errors       = 0;
    checks       = 0;
    loads        = 0;
    n_line_req   = 0;
    n_word_req   = 0;
    n_rtrn       = 0;
    n_replay     = 0;
    tb_credits   = MEM_CREDITS;
    credits_owed = 0;
    hold_credits = 1'b0;
    next_id      = '0;
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // cold miss on the first word then hits on the rest of the line
    err_start  = errors;
    word_start = n_word_req;
    for (int s = 1; s <= 3; s++) begin
      line_start = n_line_req;
      run_load(make_addr(24'h000010, 4'(s), 2), 0, -1);
      run_load(make_addr(24'h000010, 4'(s), 0), 1, -1);
      run_load(make_addr(24'h000010, 4'(s), 1), 0, -1);
      run_load(make_addr(24'h000010, 4'(s), 3), 2, -1);
      check_value("line requests", n_line_req - line_start, 1);
    end
    check_value("word requests", n_word_req - word_start, 0);
    finish_test(1, "cold misses then hits", err_start);

    // I/O region twice, then a cached line with the cache off
    err_start  = errors;
    line_start = n_line_req;
    word_start = n_word_req;
    addr = 32'h8000_1230;
    run_load(addr, 0, -1);
    run_load(addr, 1, -1);
    cache_en = 1'b0;
    run_load(make_addr(24'h000010, 4'd1, 0), 0, -1);
    run_load(make_addr(24'h000010, 4'd1, 0), 0, -1);
    check_value("word requests", n_word_req - word_start, 4);
    cache_en = 1'b1;
    // line of test 1 still resident
    run_load(make_addr(24'h000010, 4'd1, 0), 0, -1);
    check_value("word requests", n_word_req - word_start, 4);
    check_value("line requests", n_line_req - line_start, 0);
    finish_test(2, "noncacheable loads", err_start);

    // three lines into set 6 with two ways
    err_start  = errors;
    line_start = n_line_req;
    for (int i = 1; i <= 3; i++) begin
      run_load(make_addr(24'(i << 8), 4'd6, 0), 0, -1);
    end
    check_value("line requests", n_line_req - line_start, 3);
    line_start = n_line_req;
    run_load(make_addr(24'h000300, 4'd6, 1), 0, -1);
    check_value("line requests", n_line_req - line_start, 0);
    // one of the first two was evicted
    run_load(make_addr(24'h000100, 4'd6, 2), 1, -1);
    run_load(make_addr(24'h000200, 4'd6, 3), 0, -1);
    d = n_line_req - line_start;
    check_value("reload line requests in 1..2", (d >= 1 && d <= 2), 1);
    finish_test(3, "replacement", err_start);

    // kill before the tag, during a line miss and during a word miss
    err_start = errors;
    run_load(make_addr(24'h000010, 4'd2, 1), 3, 1);
    run_load(make_addr(24'h000400, 4'd7, 0), 0, 2);
    run_load(make_addr(24'h000400, 4'd7, 1), 0, -1);
    run_load(32'h8000_0040, 0, 2);
    wait_quiet();
    check_value("memory returns", n_rtrn, n_line_req + n_word_req);
    check_value("loads outstanding", exp_id.size(), 0);
    finish_test(4, "kill", err_start);

    // third miss has to replay while credits are held
    err_start    = errors;
    line_start   = n_line_req;
    replay_start = n_replay;
    hold_credits = 1'b1;
    fork
      begin
        repeat (60) @(posedge clk);
        #2;
        hold_credits = 1'b0;
      end
    join_none
    for (int i = 0; i < 4; i++) begin
      run_load(make_addr(24'(32'h500 + i), 4'(8 + i), i), 0, -1);
    end
    check_value("line requests", n_line_req - line_start, 4);
    check_value("miss replays seen", n_replay > replay_start, 1);
    wait_quiet();
    finish_test(5, "credit back-pressure", err_start);

    // small tag pool so hits and evictions mix
    err_start = errors;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      tag = 24'h000020 + 24'($urandom_range(0, 5));
      if ($urandom_range(0, 9) == 0) begin
        tag[NC_REGION_BIT-IDX_W-OFF_W] = 1'b1;
      end
      addr      = make_addr(tag, 4'($urandom_range(0, 15)), $urandom_range(0, 3));
      tag_delay = $urandom_range(0, 3);
      kill_at   = ($urandom_range(0, 15) == 0) ? int'($urandom_range(0, 5)) : -1;
      run_load(addr, tag_delay, kill_at);
    end
    wait_quiet();
    check_value("memory returns", n_rtrn, n_line_req + n_word_req);
    finish_test(6, "random traffic", err_start);

    $display("loads %0d, checks %0d, errors %0d", loads, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
dcache_pkg.sv
dcache_rd_ctrl.sv
dcache_mem.sv
dcache_miss_unit.sv
dcache_top.sv
tb_dcache_assert.sv
tb_dcache.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - dcache_pkg.sv
  - dcache_rd_ctrl.sv
  - dcache_mem.sv
  - dcache_miss_unit.sv
  - dcache_top.sv
  - target: test
    files:
      - tb_dcache_assert.sv
      - tb_dcache.sv
